// File: hw/tcdm_consts.svh
//////////////////////////////////////////////////////////////////////
// tcdm sizing constants shared by package and rtl
//////////////////////////////////////////////////////////////////////

`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// masters sharing the scratchpad
`define NUM_MASTER 4
// word-interleaved banks
`define NUM_BANKS 8
// word width in bits
`define DATA_WIDTH 32
// log2 of words per bank
`define MEM_ADDR_BITS 4
// statistics counter width
`define CNT_WIDTH 16

`endif

// File: hw/tcdm_pkg.sv
//////////////////////////////////////////////////////////////////////
// tcdm shared types: opcodes, indices, payload and counters
//////////////////////////////////////////////////////////////////////

`include "tcdm_consts.svh"

package tcdm_pkg;

  // request opcode
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcdm_op_e;

  // indices and payload
  typedef logic [$clog2(`NUM_MASTER)-1:0] master_idx_t;
  typedef logic [$clog2(`NUM_BANKS)-1:0]  bank_idx_t;
  typedef logic [`MEM_ADDR_BITS-1:0]      bank_addr_t;
  typedef logic [`DATA_WIDTH-1:0]         data_t;
  typedef logic [`DATA_WIDTH/8-1:0]       be_t;

  // wrapping statistics counter
  typedef logic [`CNT_WIDTH-1:0] cnt_t;

  // counter class on the select port
  typedef enum logic [1:0] {stat_req, stat_gnt, stat_wait, stat_load} stat_kind_e;

endpackage

// File: hw/tcdm_bank_if.sv
//////////////////////////////////////////////////////////////////////
// one bank: access from the crossbar, read response from memory
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface tcdm_bank_if import tcdm_pkg::*; ();

  // access side, bank always accepts
  logic        access_valid;
  tcdm_op_e    op;
  bank_addr_t  addr;
  data_t       wdata;
  be_t         be;
  master_idx_t idx;

  // response side, valid only
  logic        resp_valid;
  data_t       resp_rdata;
  master_idx_t resp_idx;

  modport xbar (output access_valid, op, addr, wdata, be, idx);

  modport mem (
    input  access_valid, op, addr, wdata, be, idx,
    output resp_valid, resp_rdata, resp_idx
  );

  modport router (input resp_valid, resp_rdata, resp_idx);

endinterface

// File: hw/tcdm_xbar.sv
//////////////////////////////////////////////////////////////////////
// tcdm crossbar: address decode and per-bank round-robin grant
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tcdm_xbar import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`NUM_MASTER-1:0] req_valid_i,
  input  tcdm_op_e               req_op_i    [`NUM_MASTER],
  input  logic [31:0]            req_addr_i  [`NUM_MASTER],
  input  data_t                  req_wdata_i [`NUM_MASTER],
  input  be_t                    req_be_i    [`NUM_MASTER],
  output logic [`NUM_MASTER-1:0] req_ready_o,
  tcdm_bank_if.xbar              bank_io     [`NUM_BANKS]
);

  // byte offset first, then bank bits, then bank word address
  localparam int unsigned BankLsb = $clog2(`DATA_WIDTH/8);
  localparam int unsigned AddrLsb = BankLsb + $bits(bank_idx_t);

  bank_idx_t              bank_sel   [`NUM_MASTER];
  bank_addr_t             bank_waddr [`NUM_MASTER];
  logic [`NUM_MASTER-1:0] gnt        [`NUM_BANKS];

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  for (genvar m = 0; m < `NUM_MASTER; m++) begin : g_decode
    assign bank_sel[m]   = req_addr_i[m][BankLsb +: $bits(bank_idx_t)];
    assign bank_waddr[m] = req_addr_i[m][AddrLsb +: $bits(bank_addr_t)];
  end

  //////////////////////////////////////////////////////////////////////
  // per-bank arbitration
  //////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_arb
    // rr_q holds the master with top priority next
    master_idx_t            rr_q;
    master_idx_t            winner;
    logic                   found;
    logic [`NUM_MASTER-1:0] hit;
    logic [`NUM_MASTER-1:0] gnt_b;

    always_comb begin
      for (int m = 0; m < `NUM_MASTER; m++) begin
        hit[m] = req_valid_i[m] && (bank_sel[m] == bank_idx_t'(b));
      end
    end

    // first requester at or after the pointer, wrapping
    always_comb begin
      master_idx_t cand;
      found  = 1'b0;
      winner = rr_q;
      gnt_b  = '0;
      for (int k = 0; k < `NUM_MASTER; k++) begin
        cand = master_idx_t'(rr_q + k);
        if (!found && hit[cand]) begin
          found  = 1'b1;
          winner = cand;
        end
      end
      if (found) begin
        gnt_b[winner] = 1'b1;
      end
    end

    assign gnt[b] = gnt_b;

    // pointer moves past the winner on every grant
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (found) begin
        rr_q <= winner + 1'b1;
      end
    end

    // forward the winning request
    assign bank_io[b].access_valid = found;
    assign bank_io[b].op           = req_op_i[winner];
    assign bank_io[b].addr         = bank_waddr[winner];
    assign bank_io[b].wdata        = req_wdata_i[winner];
    assign bank_io[b].be           = req_be_i[winner];
    assign bank_io[b].idx          = winner;
  end

  // ready = granted by any bank
  always_comb begin
    req_ready_o = '0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      req_ready_o |= gnt[b];
    end
  end

  for (genvar m = 0; m < `NUM_MASTER; m++) begin : g_chk
    a_gnt_needs_valid : assert property (
      @(posedge clk_i) disable iff (!rst_ni) req_ready_o[m] |-> req_valid_i[m]
    ) else $error("master %0d granted without valid", m);

    // only the decoded bank may grant this master
    a_ready_from_bank : assert property (
      @(posedge clk_i) disable iff (!rst_ni) req_ready_o[m] == gnt[bank_sel[m]][m]
    ) else $error("master %0d ready does not match its bank grant", m);
  end

endmodule

// File: hw/tcdm_bank_mem.sv
//////////////////////////////////////////////////////////////////////
// banked scratchpad: byte-enable writes, one-cycle read response
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tcdm_bank_mem import tcdm_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  tcdm_bank_if.mem bank_io [`NUM_BANKS]
);

  localparam int unsigned Words = 2 ** `MEM_ADDR_BITS;

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
    data_t       mem_q [Words];
    logic        rd_en;
    logic        wr_en;
    logic        rd_valid_q;
    data_t       rd_data_q;
    master_idx_t rd_idx_q;

    assign rd_en = bank_io[b].access_valid && (bank_io[b].op == op_read);
    assign wr_en = bank_io[b].access_valid && (bank_io[b].op == op_write);

    // storage clears to zero, writes merge enabled bytes only
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int w = 0; w < Words; w++) begin
          mem_q[w] <= '0;
        end
      end else if (wr_en) begin
        for (int j = 0; j < `DATA_WIDTH/8; j++) begin
          if (bank_io[b].be[j]) begin
            mem_q[bank_io[b].addr][j*8 +: 8] <= bank_io[b].wdata[j*8 +: 8];
          end
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rd_valid_q <= 1'b0;
      end else begin
        rd_valid_q <= rd_en;
      end
    end

    // read data is the old word when read and write share an edge
    always_ff @(posedge clk_i) begin
      if (rd_en) begin
        rd_data_q <= mem_q[bank_io[b].addr];
        rd_idx_q  <= bank_io[b].idx;
      end
    end

    assign bank_io[b].resp_valid = rd_valid_q;
    assign bank_io[b].resp_rdata = rd_data_q;
    assign bank_io[b].resp_idx   = rd_idx_q;

    a_no_write_resp : assert property (
      @(posedge clk_i) disable iff (!rst_ni) wr_en |=> !bank_io[b].resp_valid
    ) else $error("bank %0d answered a write", b);
  end

endmodule

// File: hw/tcdm_resp_router.sv
//////////////////////////////////////////////////////////////////////
// response router: bank read data back to the requesting master
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tcdm_resp_router import tcdm_pkg::*; (
  tcdm_bank_if.router            bank_io      [`NUM_BANKS],
  output logic [`NUM_MASTER-1:0] resp_valid_o,
  output data_t                  resp_rdata_o [`NUM_MASTER]
);

  logic                 bank_vld   [`NUM_BANKS];
  master_idx_t          bank_idx   [`NUM_BANKS];
  data_t                bank_rdata [`NUM_BANKS];
  logic [`NUM_BANKS-1:0] hit       [`NUM_MASTER];

  // flatten the interface array
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_flat
    assign bank_vld[b]   = bank_io[b].resp_valid;
    assign bank_idx[b]   = bank_io[b].resp_idx;
    assign bank_rdata[b] = bank_io[b].resp_rdata;
  end

  for (genvar m = 0; m < `NUM_MASTER; m++) begin : g_master
    for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_hit
      assign hit[m][b] = bank_vld[b] && (bank_idx[b] == master_idx_t'(m));
    end

    assign resp_valid_o[m] = |hit[m];

    // or-mux, a master has one outstanding read at most
    always_comb begin
      resp_rdata_o[m] = '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
        if (hit[m][b]) begin
          resp_rdata_o[m] = bank_rdata[b];
        end
      end
      a_one_bank : assert #0 ($onehot0(hit[m]))
        else $error("several banks respond to master %0d", m);
    end
  end

endmodule

// File: hw/tcdm_perf_counters.sv
//////////////////////////////////////////////////////////////////////
// tcdm statistics: request, grant, wait and bank load counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tcdm_perf_counters import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`NUM_MASTER-1:0] req_valid_i,
  input  logic [`NUM_MASTER-1:0] req_ready_i,
  input  logic [`NUM_BANKS-1:0]  bank_access_i,
  input  stat_kind_e             stat_kind_i,
  input  bank_idx_t              stat_idx_i,
  output cnt_t                   stat_o
);

  cnt_t        req_cnt_q  [`NUM_MASTER];
  cnt_t        gnt_cnt_q  [`NUM_MASTER];
  cnt_t        wait_cnt_q [`NUM_MASTER];
  cnt_t        load_cnt_q [`NUM_BANKS];
  master_idx_t stat_midx;

  //////////////////////////////////////////////////////////////////////
  // event counting, all counters wrap
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_cnt_q  <= '{default: '0};
      gnt_cnt_q  <= '{default: '0};
      wait_cnt_q <= '{default: '0};
      load_cnt_q <= '{default: '0};
    end else begin
      for (int m = 0; m < `NUM_MASTER; m++) begin
        // cycles with valid
        if (req_valid_i[m]) begin
          req_cnt_q[m] <= req_cnt_q[m] + 1'b1;
        end
        // handshakes
        if (req_valid_i[m] && req_ready_i[m]) begin
          gnt_cnt_q[m] <= gnt_cnt_q[m] + 1'b1;
        end
        // lost arbitration
        if (req_valid_i[m] && !req_ready_i[m]) begin
          wait_cnt_q[m] <= wait_cnt_q[m] + 1'b1;
        end
      end
      for (int b = 0; b < `NUM_BANKS; b++) begin
        if (bank_access_i[b]) begin
          load_cnt_q[b] <= load_cnt_q[b] + 1'b1;
        end
      end
    end
  end

  // master counters use the low index bits
  assign stat_midx = stat_idx_i[$bits(master_idx_t)-1:0];

  always_comb begin
    case (stat_kind_i)
      stat_req:  stat_o = req_cnt_q[stat_midx];
      stat_gnt:  stat_o = gnt_cnt_q[stat_midx];
      stat_wait: stat_o = wait_cnt_q[stat_midx];
      stat_load: stat_o = load_cnt_q[stat_idx_i];
      default:   stat_o = '0;
    endcase
  end

endmodule

// File: hw/tcdm_top.sv
//////////////////////////////////////////////////////////////////////
// tcdm top: crossbar, banked memory, response router and counters
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tcdm_top import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // master requests
  input  logic [`NUM_MASTER-1:0] req_valid_i,
  output logic [`NUM_MASTER-1:0] req_ready_o,
  input  tcdm_op_e               req_op_i     [`NUM_MASTER],
  input  logic [31:0]            req_addr_i   [`NUM_MASTER],
  input  data_t                  req_wdata_i  [`NUM_MASTER],
  input  be_t                    req_be_i     [`NUM_MASTER],
  // read responses
  output logic [`NUM_MASTER-1:0] resp_valid_o,
  output data_t                  resp_rdata_o [`NUM_MASTER],
  // statistics select port
  input  stat_kind_e             stat_kind_i,
  input  bank_idx_t              stat_idx_i,
  output cnt_t                   stat_o
);

  tcdm_bank_if bank_if [`NUM_BANKS] ();

  logic [`NUM_BANKS-1:0] bank_access;

  // bank load taps
  for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_load
    assign bank_access[b] = bank_if[b].access_valid;
  end

  tcdm_xbar i_xbar (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_op_i    (req_op_i),
    .req_addr_i  (req_addr_i),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i),
    .req_ready_o (req_ready_o),
    .bank_io     (bank_if)
  );

  tcdm_bank_mem i_bank_mem (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bank_io (bank_if)
  );

  tcdm_resp_router i_resp_router (
    .bank_io      (bank_if),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

  tcdm_perf_counters i_perf_counters (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_i   (req_ready_o),
    .bank_access_i (bank_access),
    .stat_kind_i   (stat_kind_i),
    .stat_idx_i    (stat_idx_i),
    .stat_o        (stat_o)
  );

endmodule

// File: testbench/tb_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset source
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset low for three cycles
  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: testbench/tb_checker.sv
//////////////////////////////////////////////////////////////////////
// tcdm scoreboard: reference memory, response and counter checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tb_checker import tcdm_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`NUM_MASTER-1:0] req_valid_i,
  input  logic [`NUM_MASTER-1:0] req_ready_i,
  input  tcdm_op_e               req_op_i     [`NUM_MASTER],
  input  logic [31:0]            req_addr_i   [`NUM_MASTER],
  input  data_t                  req_wdata_i  [`NUM_MASTER],
  input  be_t                    req_be_i     [`NUM_MASTER],
  input  logic [`NUM_MASTER-1:0] resp_valid_i,
  input  data_t                  resp_rdata_i [`NUM_MASTER],
  input  logic                   sweep_i,
  input  stat_kind_e             stat_kind_i,
  input  bank_idx_t              stat_idx_i,
  input  cnt_t                   stat_i,
  output int unsigned            err_cnt_o,
  output int unsigned            check_cnt_o
);

  // word index is bank address above bank index, byte address 8:2
  localparam int unsigned Words = `NUM_BANKS * (2 ** `MEM_ADDR_BITS);

  data_t       ref_mem   [Words];
  cnt_t        req_cnt   [`NUM_MASTER];
  cnt_t        gnt_cnt   [`NUM_MASTER];
  cnt_t        wait_cnt  [`NUM_MASTER];
  cnt_t        load_cnt  [`NUM_BANKS];
  int unsigned wait_run  [`NUM_MASTER];
  logic        pend_rd   [`NUM_MASTER];
  data_t       pend_data [`NUM_MASTER];
  int unsigned err_cnt   = 0;
  int unsigned check_cnt = 0;

  assign err_cnt_o   = err_cnt;
  assign check_cnt_o = check_cnt;

  initial begin
    for (int w = 0; w < Words; w++) begin
      ref_mem[w] = '0;
    end
    for (int m = 0; m < `NUM_MASTER; m++) begin
      req_cnt[m]   = '0;
      gnt_cnt[m]   = '0;
      wait_cnt[m]  = '0;
      wait_run[m]  = 0;
      pend_rd[m]   = 1'b0;
      pend_data[m] = '0;
    end
    for (int b = 0; b < `NUM_BANKS; b++) begin
      load_cnt[b] = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  // response belongs to the read accepted one cycle before
  task automatic check_response(input int m);
    check_cnt++;
    if (resp_valid_i[m] && !pend_rd[m]) begin
      $display("master %0d got a response without a read the cycle before", m);
      err_cnt++;
    end else if (!resp_valid_i[m] && pend_rd[m]) begin
      $display("master %0d got no response one cycle after its read", m);
      err_cnt++;
    end else if (pend_rd[m] && resp_rdata_i[m] !== pend_data[m]) begin
      $display("Fail t=%0t resp_rdata_o[%0d] expected=%h actual=%h",
               $time, m, pend_data[m], resp_rdata_i[m]);
      err_cnt++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // request side: handshakes, memory model, counts
  //////////////////////////////////////////////////////////////////////

  task automatic account_request(input int m);
    logic        hs;
    int unsigned widx;
    int unsigned bank;
    hs   = req_valid_i[m] && req_ready_i[m];
    widx = req_addr_i[m][8:2];
    bank = req_addr_i[m][4:2];
    pend_rd[m] = hs && (req_op_i[m] == op_read);
    if (req_valid_i[m]) begin
      req_cnt[m] = cnt_t'(req_cnt[m] + 1);
    end
    if (hs) begin
      gnt_cnt[m]     = cnt_t'(gnt_cnt[m] + 1);
      load_cnt[bank] = cnt_t'(load_cnt[bank] + 1);
      wait_run[m]    = 0;
      if (req_op_i[m] == op_read) begin
        pend_data[m] = ref_mem[widx];
      end else begin
        // merge enabled bytes only
        for (int j = 0; j < `DATA_WIDTH/8; j++) begin
          if (req_be_i[m][j]) begin
            ref_mem[widx][j*8 +: 8] = req_wdata_i[m][j*8 +: 8];
          end
        end
      end
    end else if (req_valid_i[m]) begin
      wait_cnt[m] = cnt_t'(wait_cnt[m] + 1);
      wait_run[m]++;
      if (wait_run[m] > 3) begin
        $display("master %0d waited more than three cycles for a grant", m);
        err_cnt++;
      end
    end
  endtask

  // one counter read from the select port
  task automatic check_counter();
    cnt_t exp_val;
    case (stat_kind_i)
      stat_req:  exp_val = req_cnt[stat_idx_i[1:0]];
      stat_gnt:  exp_val = gnt_cnt[stat_idx_i[1:0]];
      stat_wait: exp_val = wait_cnt[stat_idx_i[1:0]];
      default:   exp_val = load_cnt[stat_idx_i];
    endcase
    check_cnt++;
    if (stat_i !== exp_val) begin
      $display("Fail t=%0t stat_o[%s %0d] expected=%0d actual=%0d",
               $time, stat_kind_i.name(), stat_idx_i, exp_val, stat_i);
      err_cnt++;
    end
  endtask

  // mid-cycle sampling, all inputs settled
  always @(negedge clk_i) begin
    if (rst_ni === 1'b0) begin
      check_cnt++;
      if (req_ready_i != '0 || resp_valid_i != '0) begin
        $display("ready or response seen while reset is asserted");
        err_cnt++;
      end
    end else if (rst_ni === 1'b1) begin
      for (int m = 0; m < `NUM_MASTER; m++) begin
        check_response(m);
        account_request(m);
      end
      if (sweep_i) begin
        check_counter();
      end
    end
  end

endmodule

// File: testbench/tb_tcdm.sv
//////////////////////////////////////////////////////////////////////
// tcdm testbench top: file-driven masters, counter sweep, watchdog
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tcdm_consts.svh"

module tb_tcdm import tcdm_pkg::*; ();

  localparam int unsigned MaxLines = 64;
  // master, opcode, address, write data, byte enables
  localparam int unsigned Fields   = 5;

  logic                   clk;
  logic                   rst_n;
  logic [`NUM_MASTER-1:0] req_valid;
  logic [`NUM_MASTER-1:0] req_ready;
  tcdm_op_e               req_op     [`NUM_MASTER];
  logic [31:0]            req_addr   [`NUM_MASTER];
  data_t                  req_wdata  [`NUM_MASTER];
  be_t                    req_be     [`NUM_MASTER];
  logic [`NUM_MASTER-1:0] resp_valid;
  data_t                  resp_rdata [`NUM_MASTER];
  stat_kind_e             stat_kind;
  bank_idx_t              stat_idx;
  cnt_t                   stat;
  logic                   sweep_en;
  logic                   traffic_en;
  logic                   loaded;
  int unsigned            err_cnt;
  int unsigned            check_cnt;

  // per-master request queues as line indices into the data file
  logic [31:0]            td      [MaxLines*Fields];
  int unsigned            job     [`NUM_MASTER][MaxLines];
  int unsigned            job_cnt [`NUM_MASTER];
  int unsigned            job_ptr [`NUM_MASTER];
  int unsigned            gap     [`NUM_MASTER];
  int unsigned            num_lines;
  logic [31:0]            rng;

  tb_clock_gen i_clock_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcdm_top dut (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_o  (req_ready),
    .req_op_i     (req_op),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_be_i     (req_be),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .stat_kind_i  (stat_kind),
    .stat_idx_i   (stat_idx),
    .stat_o       (stat)
  );

  tb_checker i_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_ready_i  (req_ready),
    .req_op_i     (req_op),
    .req_addr_i   (req_addr),
    .req_wdata_i  (req_wdata),
    .req_be_i     (req_be),
    .resp_valid_i (resp_valid),
    .resp_rdata_i (resp_rdata),
    .sweep_i      (sweep_en),
    .stat_kind_i  (stat_kind),
    .stat_idx_i   (stat_idx),
    .stat_i       (stat),
    .err_cnt_o    (err_cnt),
    .check_cnt_o  (check_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // data file and queues
  //////////////////////////////////////////////////////////////////////

  // unread words keep the all-ones marker
  task automatic load_testdata();
    int unsigned m;
    for (int i = 0; i < MaxLines*Fields; i++) begin
      td[i] = 32'hffff_ffff;
    end
    $readmemh("testbench/tcdm_testdata.txt", td);
    num_lines = 0;
    for (int i = 0; i < MaxLines; i++) begin
      m = td[i*Fields];
      if (m < `NUM_MASTER) begin
        job[m][job_cnt[m]] = i;
        job_cnt[m]++;
        num_lines++;
      end
    end
  endtask

  task automatic drive_request(input int m);
    int unsigned j;
    j = job[m][job_ptr[m]] * Fields;
    req_op[m]    <= tcdm_op_e'(td[j+1][0]);
    req_addr[m]  <= td[j+2];
    req_wdata[m] <= td[j+3];
    req_be[m]    <= be_t'(td[j+4]);
    req_valid[m] <= 1'b1;
  endtask

  function automatic logic traffic_done();
    for (int m = 0; m < `NUM_MASTER; m++) begin
      if (job_ptr[m] < job_cnt[m] || req_valid[m]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // every counter once, checker compares while sweep_en is high
  task automatic read_counters();
    int unsigned n;
    for (int k = 0; k < 4; k++) begin
      n = (stat_kind_e'(k) == stat_load) ? `NUM_BANKS : `NUM_MASTER;
      for (int i = 0; i < n; i++) begin
        @(posedge clk);
        stat_kind <= stat_kind_e'(k);
        stat_idx  <= bank_idx_t'(i);
        sweep_en  <= 1'b1;
      end
    end
    @(posedge clk);
    sweep_en <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // master drivers
  //////////////////////////////////////////////////////////////////////

  // hold until ready, then next entry after a 0 to 2 cycle gap
  always @(posedge clk) begin
    if (traffic_en) begin
      for (int m = 0; m < `NUM_MASTER; m++) begin
        if (req_valid[m] && req_ready[m]) begin
          job_ptr[m] = job_ptr[m] + 1;
          rng        = xorshift32(rng);
          gap[m]     = rng % 3;
          if (gap[m] == 0 && job_ptr[m] < job_cnt[m]) begin
            drive_request(m);
          end else begin
            req_valid[m] <= 1'b0;
          end
        end else if (!req_valid[m] && job_ptr[m] < job_cnt[m]) begin
          if (gap[m] <= 1) begin
            drive_request(m);
          end else begin
            gap[m] = gap[m] - 1;
          end
        end
      end
    end
  end

  initial begin
    req_valid  = '0;
    sweep_en   = 1'b0;
    traffic_en = 1'b0;
    loaded     = 1'b0;
    stat_kind  = stat_req;
    stat_idx   = '0;
    rng        = 32'hd725_0fa5;
    for (int m = 0; m < `NUM_MASTER; m++) begin
      req_op[m]    = op_read;
      req_addr[m]  = '0;
      req_wdata[m] = '0;
      req_be[m]    = '0;
      job_cnt[m]   = 0;
      job_ptr[m]   = 0;
      gap[m]       = 0;
    end
    load_testdata();
    loaded = 1'b1;
    if (num_lines == 0) begin
      $display("no requests found in the test data file");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      wait (rst_n === 1'b1);
      // counters must still read zero
      read_counters();
      @(posedge clk);
      traffic_en <= 1'b1;
      do begin
        @(negedge clk);
      end while (!traffic_done());
      repeat (2) @(posedge clk);
      read_counters();
      @(posedge clk);
      $display("checks %0d errors %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

  // watchdog scaled by the data file length
  initial begin
    wait (loaded === 1'b1);
    repeat (50 * num_lines + 100) @(posedge clk);
    $display("timeout: requests did not complete within %0d cycles",
             50 * num_lines + 100);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: testbench/tcdm_testdata.txt
// columns: master opcode(0 read, 1 write) byte_address write_data byte_enables
// all fields hex, one request per line, bank = addr[4:2], bank word = addr[8:5]
0 0 00000000 00000000 0
1 0 0000001c 00000000 0
0 1 00000100 a0a0a0a0 f
1 1 00000104 b1b1b1b1 f
2 1 00000108 c2c2c2c2 f
3 1 0000010c d3d3d3d3 f
2 1 00000120 11223344 f
2 1 00000120 aabbccdd 3
2 0 00000120 00000000 0
0 1 00000014 00000005 f
1 1 00000034 00000015 f
2 1 00000054 00000025 f
3 1 00000074 00000035 f
0 0 00000034 00000000 0
1 0 00000054 00000000 0
2 0 00000074 00000000 0
3 0 00000014 00000000 0
0 0 00000104 00000000 0
1 0 00000108 00000000 0
2 0 0000010c 00000000 0
3 0 00000100 00000000 0
3 1 00000124 ffeeddcc c
3 0 00000124 00000000 0

// File: sources.f
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_bank_if.sv
hw/tcdm_xbar.sv
hw/tcdm_bank_mem.sv
hw/tcdm_resp_router.sv
hw/tcdm_perf_counters.sv
hw/tcdm_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_tcdm.sv
